// File: branchPredictUnit.f
+incdir+tests
rtl/fetchPkg.sv
rtl/predictPkg.sv
rtl/multiBankRam.sv
rtl/btb.sv
rtl/directionPredictor.sv
rtl/nextPcSelect.sv
rtl/branchPredictUnit.sv
tests/tb_branchPredictUnit.sv

// File: run.sh
#!/bin/sh
# Compile and run the branch predictor testbench with Verilator.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_branchPredictUnit -f branchPredictUnit.f
./obj_dir/Vtb_branchPredictUnit 2>&1 | tee sim.log

if grep -q "Test failed" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi
if ! grep -q "Test passed" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi

// File: tests/tbRefModel.svh
// Shadow tables for the branch predictor testbench.
// Included inside the testbench module, after fetchPkg and predictPkg are imported.
// Indexes and tags are sliced straight from the PC bit ranges of the design.
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

typedef struct packed {
    pcAddr  nextPc;
    logic   taken;
    slotIdx slot;
} predExpect;

typedef struct packed {
    btbIndex idx;
    logic    isCondBr;
    btbTag   tag;
    pcAddr   target;
} pendingWrite;

logic        refValid [btbEntryNum];
logic        refCond [btbEntryNum];
btbTag       refTag [btbEntryNum];
pcAddr       refTarget [btbEntryNum];
phtCounter   refCnt [phtEntryNum];
pendingWrite refQueue [$];

// State right after both sweeps.
function automatic void resetModel();
    for (int i = 0; i < btbEntryNum; i++) begin
        refValid[i] = 1'b0;
        refCond[i] = 1'b0;
        refTag[i] = '0;
        refTarget[i] = '0;
    end
    for (int i = 0; i < phtEntryNum; i++) begin
        refCnt[i] = 2'd1;
    end
    refQueue.delete();
endfunction

function automatic void installEntry(input pendingWrite w);
    refValid[w.idx] = 1'b1;
    refCond[w.idx] = w.isCondBr;
    refTag[w.idx] = w.tag;
    refTarget[w.idx] = w.target;
endfunction

// Clamped step of the counter read at prediction time.
function automatic phtCounter stepCounter(input phtCounter prev, input logic taken);
    int v;
    v = int'(prev) + (taken ? 1 : -1);
    if (v > 3) begin
        v = 3;
    end
    if (v < 0) begin
        v = 0;
    end
    return phtCounter'(v);
endfunction

// One cycle of resolved branches, in issue order.
function automatic void applyUpdates(input branchResult res [intIssueWidth]);
    logic        wrote;
    pendingWrite w;
    wrote = 1'b0;
    for (int i = 0; i < intIssueWidth; i++) begin
        if (res[i].valid && res[i].taken) begin
            w.idx = res[i].brAddr[7:2];
            w.isCondBr = res[i].isCondBr;
            w.tag = res[i].brAddr[31:8];
            w.target = res[i].target;
            if (!wrote) begin
                installEntry(w);
                wrote = 1'b1;
            end else if (refQueue.size() < btbQueueSize) begin
                refQueue.push_back(w);
            end
        end
    end
    // The queue drains only when the write port is free.
    if (!wrote && refQueue.size() > 0) begin
        installEntry(refQueue.pop_front());
    end
    // Later slots overwrite earlier ones on the same counter.
    for (int i = 0; i < intIssueWidth; i++) begin
        if (res[i].valid && res[i].isCondBr) begin
            refCnt[res[i].brAddr[9:2]] = stepCounter(res[i].prevCounter, res[i].taken);
        end
    end
endfunction

// First slot that hits and is taken decides the next PC.
function automatic predExpect predictNext(input pcAddr pc);
    predExpect e;
    pcAddr     slotPc;
    btbIndex   idx;
    logic      hit;
    logic      dirTaken;
    e.nextPc = pc + 32'd8;
    e.taken = 1'b0;
    e.slot = '0;
    for (int s = 0; s < fetchWidth; s++) begin
        slotPc = pc + pcAddr'(4 * s);
        idx = slotPc[7:2];
        hit = refValid[idx] && (refTag[idx] == slotPc[31:8]);
        dirTaken = !refCond[idx] || (refCnt[slotPc[9:2]] >= 2'd2);
        if (hit && dirTaken && !e.taken) begin
            e.taken = 1'b1;
            e.slot = slotIdx'(s);
            e.nextPc = refTarget[idx];
        end
    end
    return e;
endfunction

`endif

// File: tests/tb_branchPredictUnit.sv
`timescale 1ns/1ps
// Testbench for the branch prediction unit.
// Expected predictions come from the shadow tables in tbRefModel.svh.
// Each driven lookup is compared at the falling edge after the DUT registers it.
// Random updates never push into a full BTB queue.

module tb_branchPredictUnit
    import fetchPkg::*, predictPkg::*;
();

    // Reset and sweeps take about 270 cycles, directed tests under 100
    // and the random phase 1000, so this leaves a wide margin.
    localparam int maxCycles = 5000;
    localparam int randomCycles = 1000;

    logic        clk;
    logic        rst;
    pcAddr       fetchPc;
    branchResult brResult [intIssueWidth];
    pcAddr       nextPc;
    logic        predTaken;
    slotIdx      predSlot;
    logic        ready;

    int cycleCount = 0;

    `include "tbRefModel.svh"

    typedef struct packed {
        predExpect pred;
        pcAddr     pc;
        int        due;
    } lookupRecord;

    lookupRecord pendingLookups [$];

    branchPredictUnit u_dut (
        .clk      (clk),
        .rst      (rst),
        .fetchPc  (fetchPc),
        .brResult (brResult),
        .nextPc   (nextPc),
        .predTaken(predTaken),
        .predSlot (predSlot),
        .ready    (ready)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic failRun(input string reason);
        $display("%s", reason);
        $display("Test failed");
        $fatal(1);
    endtask

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= maxCycles) begin
            failRun("Timeout: the run did not finish within the cycle limit");
        end
    end

    task automatic checkPc(input pcAddr got, input pcAddr exp, input string what);
        if (got !== exp) begin
            failRun($sformatf("CHECK FAILED at %0t: %s nextPc %h, expected %h",
                              $time, what, got, exp));
        end
    endtask

    task automatic checkBit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            failRun($sformatf("CHECK FAILED at %0t: %s %b, expected %b",
                              $time, what, got, exp));
        end
    endtask

    task automatic checkSlot(input slotIdx got, input slotIdx exp, input string what);
        if (got !== exp) begin
            failRun($sformatf("CHECK FAILED at %0t: %s predSlot %0d, expected %0d",
                              $time, what, got, exp));
        end
    endtask

    // Outputs are stable between rising edges.
    always @(negedge clk) begin : compareOutputs
        lookupRecord rec;
        string       where;
        if (pendingLookups.size() > 0 && pendingLookups[0].due == cycleCount) begin
            rec = pendingLookups.pop_front();
            where = $sformatf("lookup pc %h", rec.pc);
            checkBit(ready, 1'b1, {where, " ready"});
            checkBit(predTaken, rec.pred.taken, {where, " predTaken"});
            checkPc(nextPc, rec.pred.nextPc, where);
            if (rec.pred.taken) begin
                checkSlot(predSlot, rec.pred.slot, where);
            end
        end
    end

    // One lookup plus up to two branch results per cycle.
    task automatic driveCycle(input pcAddr pc, input branchResult r0, input branchResult r1);
        lookupRecord rec;
        branchResult res [intIssueWidth];
        @(posedge clk);
        res[0] = r0;
        res[1] = r1;
        rec.pred = predictNext(pc);
        rec.pc = pc;
        rec.due = cycleCount + 2;
        pendingLookups.push_back(rec);
        fetchPc <= pc;
        brResult[0] <= r0;
        brResult[1] <= r1;
        applyUpdates(res);
    endtask

    task automatic idleCycles(input int n, input pcAddr pc);
        repeat (n) driveCycle(pc, '0, '0);
    endtask

    function automatic branchResult makeResult(input logic taken, input logic isCond,
                                               input pcAddr addr, input pcAddr target,
                                               input phtCounter prev);
        return '{valid: 1'b1, taken: taken, isCondBr: isCond, brAddr: addr,
                 target: target, prevCounter: prev};
    endfunction

    // Four tags over all 64 indexes, so random PCs alias in the BTB.
    function automatic pcAddr randomPc();
        return 32'h0000_4000 | (pcAddr'($urandom() % 4) << 8) | (pcAddr'($urandom() % 64) << 2);
    endfunction

    function automatic branchResult randomResult();
        branchResult r;
        r.valid = 1'($urandom());
        r.taken = 1'($urandom());
        r.isCondBr = 1'($urandom());
        r.brAddr = randomPc();
        r.target = pcAddr'($urandom()) & ~32'h3;
        r.prevCounter = refCnt[r.brAddr[9:2]];
        return r;
    endfunction

    initial begin
        pcAddr       base;
        branchResult r0;
        branchResult r1;
        void'($urandom(9));
        rst = 1'b1;
        fetchPc = '0;
        brResult[0] = '0;
        brResult[1] = '0;
        resetModel();
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        // The counter table needs one cycle per entry before ready can rise.
        repeat (phtEntryNum) begin
            @(negedge clk);
            checkBit(ready, 1'b0, "ready during the table sweep");
        end
        while (!ready) @(posedge clk);

        // Cleared tables, so every group falls through.
        for (int i = 0; i < 20; i++) begin
            driveCycle(randomPc(), '0, '0);
        end

        // Unconditional branch seen from slot 0, then from slot 1.
        base = 32'h0000_8010;
        driveCycle(base, makeResult(1'b1, 1'b0, base, 32'h0001_2340, 2'd1), '0);
        driveCycle(base, '0, '0);
        driveCycle(base - 32'd4, '0, '0);
        driveCycle(base + 32'd8, '0, '0);

        // Installed with prevCounter 0, so the counter lands on 1.
        base = 32'h0000_9020;
        driveCycle(base, makeResult(1'b1, 1'b1, base, 32'h0000_a000, 2'd0), '0);
        driveCycle(base, '0, '0);
        driveCycle(base, makeResult(1'b1, 1'b1, base, 32'h0000_a000, 2'd1), '0);
        driveCycle(base, '0, '0);
        driveCycle(base, makeResult(1'b0, 1'b1, base, 32'h0000_a000, 2'd2), '0);
        driveCycle(base, makeResult(1'b0, 1'b1, base, 32'h0000_a000, 2'd1), '0);
        driveCycle(base, '0, '0);

        // The second of two taken results goes through the queue.
        base = 32'h0000_b040;
        driveCycle(base, makeResult(1'b1, 1'b0, base, 32'h0000_c000, 2'd1),
                   makeResult(1'b1, 1'b0, base + 32'h20, 32'h0000_c100, 2'd1));
        idleCycles(3, base);
        driveCycle(base + 32'h20, '0, '0);

        // Slot 0 wins when both slots are taken.
        base = 32'h0000_d080;
        driveCycle(base, makeResult(1'b1, 1'b0, base, 32'h0000_e000, 2'd1),
                   makeResult(1'b1, 1'b0, base + 32'd4, 32'h0000_e400, 2'd1));
        idleCycles(3, base);
        // A new tag on the same index misses.
        driveCycle(base ^ 32'h0010_0000, '0, '0);

        // Mixed random traffic.
        for (int i = 0; i < randomCycles; i++) begin
            r0 = randomResult();
            r1 = randomResult();
            if (r0.valid && r0.taken && r1.valid && r1.taken &&
                refQueue.size() >= btbQueueSize) begin
                r1.valid = 1'b0;
            end
            driveCycle(randomPc(), r0, r1);
        end

        // Clear the last results so they are not applied again.
        idleCycles(1, randomPc());
        repeat (3) @(posedge clk);
        if (pendingLookups.size() == 0) begin
            $display("Test passed");
            $finish;
        end else begin
            failRun("Some lookups were never compared with the DUT outputs");
        end
    end

endmodule

// File: rtl/branchPredictUnit.sv
`timescale 1ns/1ps
// Branch prediction front of the fetch stage.
// Lookup at edge N gives nextPc, predTaken and predSlot after edge N+1.
// Wait for ready before trusting outputs or sending updates.
// No return stack, global history or indirect prediction.

module branchPredictUnit
    import fetchPkg::*, predictPkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  pcAddr       fetchPc,
    input  branchResult brResult [intIssueWidth],
    output pcAddr       nextPc,
    output logic        predTaken,
    output slotIdx      predSlot,
    output logic        ready
);

    slotPrediction         btbPred [fetchWidth];
    logic [fetchWidth-1:0] counterTaken;
    logic                  btbInitDone;
    logic                  phtInitDone;

    btb u_btb (
        .clk     (clk),
        .rst     (rst),
        .fetchPc (fetchPc),
        .brResult(brResult),
        .btbPred (btbPred),
        .initDone(btbInitDone)
    );

    directionPredictor u_directionPredictor (
        .clk         (clk),
        .rst         (rst),
        .fetchPc     (fetchPc),
        .brResult    (brResult),
        .counterTaken(counterTaken),
        .initDone    (phtInitDone)
    );

    nextPcSelect u_nextPcSelect (
        .clk         (clk),
        .rst         (rst),
        .fetchPc     (fetchPc),
        .btbPred     (btbPred),
        .counterTaken(counterTaken),
        .btbInitDone (btbInitDone),
        .phtInitDone (phtInitDone),
        .nextPc      (nextPc),
        .predTaken   (predTaken),
        .predSlot    (predSlot),
        .ready       (ready)
    );

endmodule

// File: rtl/nextPcSelect.sv
`timescale 1ns/1ps
// Picks the first taken slot of the group looked up one cycle earlier.
// Outputs are only meaningful while ready is high.

module nextPcSelect
    import fetchPkg::*, predictPkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  pcAddr                 fetchPc,
    input  slotPrediction         btbPred [fetchWidth],
    input  logic [fetchWidth-1:0] counterTaken,
    input  logic                  btbInitDone,
    input  logic                  phtInitDone,
    output pcAddr                 nextPc,
    output logic                  predTaken,
    output slotIdx                predSlot,
    output logic                  ready
);

    pcAddr                 lookupPc;
    slotPrediction         merged [fetchWidth];
    logic [fetchWidth-1:0] slotTaken;

    // Aligned with the registered table reads.
    always_ff @(posedge clk) begin
        if (rst) begin
            lookupPc <= '0;
        end else begin
            lookupPc <= fetchPc;
        end
    end

    always_comb begin
        for (int s = 0; s < fetchWidth; s++) begin
            merged[s] = btbPred[s];
            merged[s].counterTaken = counterTaken[s];
            // Unconditional hits are always taken.
            slotTaken[s] = merged[s].hit &&
                (!merged[s].isCondBr || merged[s].counterTaken);
        end
    end

    // Walk down so the lowest taken slot is the last to assign.
    always_comb begin
        predTaken = 1'b0;
        predSlot = '0;
        nextPc = lookupPc + pcAddr'(groupBytes);
        for (int s = fetchWidth - 1; s >= 0; s--) begin
            if (slotTaken[s]) begin
                predTaken = 1'b1;
                predSlot = slotIdx'(s);
                nextPc = merged[s].target;
            end
        end
    end

    assign ready = btbInitDone && phtInitDone;

endmodule

// File: rtl/directionPredictor.sv
`timescale 1ns/1ps
// Bimodal predictor, one 2-bit counter per PC[9:2].
// Updates are computed from the counter read at prediction time,
// not the current table value. Same-index updates: slot 1 wins.
// Counters are set to weakly not taken one per cycle after reset.

module directionPredictor
    import fetchPkg::*, predictPkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  pcAddr                 fetchPc,
    input  branchResult           brResult [intIssueWidth],
    output logic [fetchWidth-1:0] counterTaken,
    output logic                  initDone
);

    logic [intIssueWidth-1:0] ramWe;
    phtIndex                  ramWa [intIssueWidth];
    phtCounter                ramWv [intIssueWidth];
    phtIndex                  ramRa [fetchWidth];
    phtCounter                ramRv [fetchWidth];

    phtIndex sweepIdx;

    // Saturating step from the counter seen at prediction time.
    function automatic phtCounter nextCounter(phtCounter prev, logic taken);
        if (taken) begin
            return (prev == phtCounterMax) ? prev : prev + 1'b1;
        end
        return (prev == '0) ? prev : prev - 1'b1;
    endfunction

    multiBankRam #(
        .entryNum (phtEntryNum),
        .readNum  (fetchWidth),
        .writeNum (intIssueWidth),
        .entryType(phtCounter)
    ) counterRam (
        .clk(clk),
        .we (ramWe),
        .wa (ramWa),
        .wv (ramWv),
        .ra (ramRa),
        .rv (ramRv)
    );

    always_comb begin
        for (int s = 0; s < fetchWidth; s++) begin
            ramRa[s] = toPhtIndex(fetchPc + pcAddr'(s * insnBytes));
            counterTaken[s] = (ramRv[s] >= phtTakenMin);
        end
    end

    // Port order in the RAM gives slot 1 priority.
    always_comb begin
        for (int i = 0; i < intIssueWidth; i++) begin
            ramWe[i] = initDone && brResult[i].valid && brResult[i].isCondBr;
            ramWa[i] = toPhtIndex(brResult[i].brAddr);
            ramWv[i] = nextCounter(brResult[i].prevCounter, brResult[i].taken);
        end
        if (!initDone) begin
            ramWe[0] = !rst;
            ramWa[0] = sweepIdx;
            ramWv[0] = phtInitCounter;
        end
    end

    // Reset sweep.
    always_ff @(posedge clk) begin
        if (rst) begin
            sweepIdx <= '0;
            initDone <= 1'b0;
        end else if (!initDone) begin
            sweepIdx <= sweepIdx + 1'b1;
            if (sweepIdx == phtIndex'(phtEntryNum - 1)) begin
                initDone <= 1'b1;
            end
        end
    end

    // The fetch side must return the counter it used.
    generate
        for (genvar i = 0; i < intIssueWidth; i++) begin : gPrevCheck
            assert property (@(posedge clk) disable iff (rst)
                (brResult[i].valid && brResult[i].isCondBr) |->
                    !$isunknown(brResult[i].prevCounter))
                else $error("Unknown prevCounter on conditional update %0d", i);
        end
    endgenerate

endmodule

// File: rtl/btb.sv
`timescale 1ns/1ps
// Direct-mapped branch target buffer with one write port.
// Only taken results are installed; a second one per cycle is queued.
// A full queue drops the result. Lookup data is valid one cycle later.
// Entries are cleared one per cycle after reset; updates wait for initDone.

module btb
    import fetchPkg::*, predictPkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  pcAddr         fetchPc,
    input  branchResult   brResult [intIssueWidth],
    output slotPrediction btbPred [fetchWidth],
    output logic          initDone
);

    typedef struct packed {
        btbIndex idx;
        btbEntry entry;
    } queueEntry;

    logic [0:0] ramWe;
    btbIndex    ramWa [1];
    btbEntry    ramWv [1];
    btbIndex    ramRa [fetchWidth];
    btbEntry    ramRv [fetchWidth];

    pcAddr   lookupPc;
    btbIndex sweepIdx;

    queueEntry    queueMem [btbQueueSize];
    queueEntry    pushEntry;
    btbQueuePtr   headPtr;
    btbQueuePtr   tailPtr;
    btbQueueCount queueCount;
    logic         full;
    logic         empty;
    logic         directWrite;
    logic         pushReq;
    logic         pushQueue;
    logic         popQueue;

    function automatic btbEntry makeEntry(branchResult br);
        return '{valid: 1'b1, isCondBr: br.isCondBr,
                 tag: toBtbTag(br.brAddr), target: br.target};
    endfunction

    multiBankRam #(
        .entryNum (btbEntryNum),
        .readNum  (fetchWidth),
        .writeNum (1),
        .entryType(btbEntry)
    ) entryRam (
        .clk(clk),
        .we (ramWe),
        .wa (ramWa),
        .wv (ramWv),
        .ra (ramRa),
        .rv (ramRv)
    );

    // One read per slot.
    always_comb begin
        for (int s = 0; s < fetchWidth; s++) begin
            ramRa[s] = toBtbIndex(fetchPc + pcAddr'(s * insnBytes));
        end
    end

    // Held for the tag compare on the next cycle.
    always_ff @(posedge clk) begin
        lookupPc <= fetchPc;
    end

    always_comb begin
        for (int s = 0; s < fetchWidth; s++) begin
            btbPred[s].hit = ramRv[s].valid &&
                (ramRv[s].tag == toBtbTag(lookupPc + pcAddr'(s * insnBytes)));
            btbPred[s].isCondBr = ramRv[s].isCondBr;
            btbPred[s].target = ramRv[s].target;
            // Filled in by the direction predictor.
            btbPred[s].counterTaken = 1'b0;
        end
    end

    assign full = (queueCount == btbQueueCount'(btbQueueSize));
    assign empty = (queueCount == '0);

    // Direct write gets the port first, then the queue. The sweep overrides both.
    always_comb begin
        directWrite = 1'b0;
        pushReq = 1'b0;
        pushEntry = '0;
        ramWa[0] = '0;
        ramWv[0] = '0;
        for (int i = 0; i < intIssueWidth; i++) begin
            if (initDone && brResult[i].valid && brResult[i].taken) begin
                if (directWrite) begin
                    pushReq = 1'b1;
                    pushEntry.idx = toBtbIndex(brResult[i].brAddr);
                    pushEntry.entry = makeEntry(brResult[i]);
                end else begin
                    directWrite = 1'b1;
                    ramWa[0] = toBtbIndex(brResult[i].brAddr);
                    ramWv[0] = makeEntry(brResult[i]);
                end
            end
        end
        pushQueue = pushReq && !full;
        popQueue = initDone && !directWrite && !empty;
        if (popQueue) begin
            ramWa[0] = queueMem[tailPtr].idx;
            ramWv[0] = queueMem[tailPtr].entry;
        end
        if (!initDone) begin
            ramWa[0] = sweepIdx;
            ramWv[0] = '0;
        end
        ramWe[0] = directWrite || popQueue || (!initDone && !rst);
    end

    always_ff @(posedge clk) begin
        if (pushQueue) begin
            queueMem[headPtr] <= pushEntry;
        end
    end

    // Push needs a direct write and pop needs none, so they never coincide.
    always_ff @(posedge clk) begin
        if (rst) begin
            headPtr <= '0;
            tailPtr <= '0;
            queueCount <= '0;
        end else if (pushQueue) begin
            headPtr <= headPtr + 1'b1;
            queueCount <= queueCount + 1'b1;
        end else if (popQueue) begin
            tailPtr <= tailPtr + 1'b1;
            queueCount <= queueCount - 1'b1;
        end
    end

    // Clears one entry per cycle after reset.
    always_ff @(posedge clk) begin
        if (rst) begin
            sweepIdx <= '0;
            initDone <= 1'b0;
        end else if (!initDone) begin
            sweepIdx <= sweepIdx + 1'b1;
            if (sweepIdx == btbIndex'(btbEntryNum - 1)) begin
                initDone <= 1'b1;
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst) !(pushReq && full))
        else $error("BTB queue full, taken branch result dropped");

    // Count and pointers must agree, or a pop could read a stale slot.
    assert property (@(posedge clk) disable iff (rst)
        (queueCount <= btbQueueCount'(btbQueueSize)) &&
        (btbQueuePtr'(headPtr - tailPtr) == btbQueuePtr'(queueCount)))
        else $error("BTB queue count does not match its pointers");

endmodule

// File: rtl/multiBankRam.sv
`timescale 1ns/1ps
// Flat RAM with independent read and write ports.
// Reads are registered and return the contents before this edge's writes.
// Writes to one address in the same cycle resolve to the highest port.
// No reset; the owner must initialize the contents.

module multiBankRam #(
    parameter int  entryNum = 64,
    parameter int  readNum = 2,
    parameter int  writeNum = 1,
    parameter type entryType = logic [7:0]
) (
    input  logic                        clk,
    input  logic [writeNum-1:0]         we,
    input  logic [$clog2(entryNum)-1:0] wa [writeNum],
    input  entryType                    wv [writeNum],
    input  logic [$clog2(entryNum)-1:0] ra [readNum],
    output entryType                    rv [readNum]
);

    entryType mem [entryNum];

    // Later ports overwrite earlier ones.
    always_ff @(posedge clk) begin
        for (int w = 0; w < writeNum; w++) begin
            if (we[w]) begin
                mem[wa[w]] <= wv[w];
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int r = 0; r < readNum; r++) begin
            rv[r] <= mem[ra[r]];
        end
    end

    // A write must name a real, known entry.
    generate
        for (genvar w = 0; w < writeNum; w++) begin : gWriteCheck
            assert property (@(posedge clk)
                we[w] |-> (!$isunknown(wa[w]) && (int'(wa[w]) < entryNum)))
                else $error("RAM write port %0d address %0d out of range", w, wa[w]);
        end
    endgenerate

endmodule

// File: rtl/predictPkg.sv
// Geometry and record types of the prediction tables.
// BTB is direct-mapped, indexed by PC[7:2], tagged with PC[31:8].
// Counters are 2-bit, indexed by PC[9:2], reset to weakly not taken.

package predictPkg;

    import fetchPkg::*;

    // BTB geometry.
    localparam int btbEntryNum = 64;
    localparam int btbIndexBits = $clog2(btbEntryNum);
    localparam int btbTagBits = pcWidth - btbIndexBits - insnOffsetBits;

    typedef logic [btbIndexBits-1:0] btbIndex;
    typedef logic [btbTagBits-1:0]   btbTag;

    typedef struct packed {
        logic  valid;
        logic  isCondBr;
        btbTag tag;
        pcAddr target;
    } btbEntry;

    // Pending BTB writes that lost the write port.
    localparam int btbQueueSize = 4;

    typedef logic [$clog2(btbQueueSize)-1:0] btbQueuePtr;
    typedef logic [$clog2(btbQueueSize):0]   btbQueueCount;

    // Pattern history table geometry.
    localparam int phtEntryNum = 256;
    localparam int phtIndexBits = $clog2(phtEntryNum);

    typedef logic [phtIndexBits-1:0] phtIndex;
    typedef logic [1:0]              phtCounter;

    // Weakly not taken after the sweep; 2 and up predicts taken.
    localparam phtCounter phtInitCounter = 2'd1;
    localparam phtCounter phtTakenMin = 2'd2;
    localparam phtCounter phtCounterMax = 2'd3;

    // Resolved branches per cycle.
    localparam int intIssueWidth = 2;

    typedef struct packed {
        logic      valid;
        logic      taken;
        logic      isCondBr;
        pcAddr     brAddr;
        pcAddr     target;
        phtCounter prevCounter;
    } branchResult;

    typedef struct packed {
        logic  hit;
        logic  isCondBr;
        pcAddr target;
        logic  counterTaken;
    } slotPrediction;

    function automatic btbIndex toBtbIndex(pcAddr pc);
        return pc[insnOffsetBits +: btbIndexBits];
    endfunction

    function automatic btbTag toBtbTag(pcAddr pc);
        return pc[insnOffsetBits + btbIndexBits +: btbTagBits];
    endfunction

    function automatic phtIndex toPhtIndex(pcAddr pc);
        return pc[insnOffsetBits +: phtIndexBits];
    endfunction

endpackage

// File: rtl/fetchPkg.sv
// Address-side types for the fetch stage.
// A fetch group is fetchWidth consecutive 4-byte instructions at one PC.
// PCs are plain 32-bit byte addresses. No compressed instructions.

package fetchPkg;

    // Byte address width.
    localparam int pcWidth = 32;

    // Instruction slots per fetch group.
    localparam int fetchWidth = 2;

    // Fixed instruction size.
    localparam int insnBytes = 4;

    // Low PC bits below the instruction index.
    localparam int insnOffsetBits = $clog2(insnBytes);

    // Bytes covered by one fetch group, used for the fall-through PC.
    localparam int groupBytes = fetchWidth * insnBytes;

    typedef logic [pcWidth-1:0] pcAddr;

    // Slot number inside a fetch group.
    typedef logic [$clog2(fetchWidth)-1:0] slotIdx;

endpackage
